/* testbench/bpu_input.txt */
# test op pc type cnt ok tkn ctgt | exp_valid exp_taken exp_target exp_corr exp_ctgt (hex)
# type 0 none 1 cond 2 jump 3 call 4 return; ok is predict_success, tkn is is_taken
1 fetch 00001000 0 0 0 0 00000000 0 0 00001008 0 00000000
1 fetch 12345670 0 0 0 0 00000000 0 0 12345678 0 00000000
2 verify 00002010 1 1 0 1 00003000 0 0 00002018 0 00000000
2 fetch 00002010 0 0 0 0 00000000 0 0 00002018 1 00003000
2 fetch 00002010 0 0 0 0 00000000 1 1 00003000 0 00000000
2 verify 00002010 1 2 1 1 00003000 0 0 00002018 0 00000000
2 verify 00002010 1 3 1 0 00003000 0 0 00002018 0 00000000
2 fetch 00002010 0 0 0 0 00000000 1 1 00003000 0 00000000
2 verify 00002010 1 2 1 0 00003000 0 0 00002018 0 00000000
2 fetch 00002010 0 0 0 0 00000000 1 0 00002018 0 00000000
3 verify 00004020 2 0 1 1 00005000 0 0 00004028 0 00000000
3 fetch 00004020 0 0 0 0 00000000 1 1 00005000 0 00000000
3 fetch 00014020 0 0 0 0 00000000 0 0 00014028 0 00000000
4 verify 00006030 3 0 1 1 00007050 0 0 00006038 0 00000000
4 verify 00006040 3 0 1 1 00007050 0 0 00006048 0 00000000
4 verify 00007050 4 0 1 1 00006048 0 0 00007058 0 00000000
4 fetch 00007050 0 0 0 0 00000000 1 1 00006038 0 00000000
4 verify 00007050 4 0 1 1 00006038 0 0 00007058 0 00000000
4 fetch 00007050 0 0 0 0 00000000 1 1 00000000 0 00000000
5 verify 00008060 1 1 0 1 00009000 0 0 00008068 0 00000000
5 fetch 00008060 0 0 0 0 00000000 0 0 00008068 1 00009000
5 fetch 00008060 0 0 0 0 00000000 1 1 00009000 0 00000000
5 verify 00008060 1 2 0 0 00008068 0 0 00008068 0 00000000
5 verify 00008070 1 1 0 1 0000a000 0 0 00008078 1 00008068
5 idle 00000000 0 0 0 0 00000000 0 0 00000008 0 00000000
5 fetch 00008060 0 0 0 0 00000000 1 0 00008068 0 00000000
6 verify 00008070 1 2 0 0 00008078 0 0 00008078 0 00000000
6 flush 00000000 0 0 0 0 00000000 0 0 00000008 1 00008078
6 idle 00000000 0 0 0 0 00000000 0 0 00000008 0 00000000
6 fetch 00008070 0 0 0 0 00000000 1 0 00008078 0 00000000

/* sim.f */
src/bpu_types_pkg.sv
src/bpu_bus_pkg.sv
src/entry_ram.sv
src/bht_update.sv
src/ras.sv
src/predict_select.sv
src/bpu_ctrl.sv
src/bpu_top.sv
testbench/tb_clock.sv
testbench/bpu_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = bpu_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the simulation"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* testbench/bpu_tb.sv */
// branch prediction unit testbench
`timescale 1ns/1ps

module bpu_tb
    import bpu_types_pkg::*;
    import bpu_bus_pkg::*;
();

    localparam int max_cycles   = 2000;
    localparam int reset_cycles = 8;
    localparam int quiet_limit  = 20;
    localparam int bht_bits     = 10;

    logic       clk;
    logic       rst;
    fetch_req_t fetch;
    verify_t    verify;
    flush_t     flush;
    predict_t   predict;

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int line_no;
    int seed;

    // expected bht contents by index, absent means zeroed
    bht_entry_t bht_model [int];

    tb_clock #(.half_period(20)) u_clock (.clk(clk));

    bpu_top #(
        .bht_index_bits (bht_bits),
        .ras_depth_bits (3)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .fetch   (fetch),
        .verify  (verify),
        .flush   (flush),
        .predict (predict)
    );

    // test numbers in the stimulus file map to these
    function automatic string test_name(input int num);
        case (num)
            1: return "reset_fall_through";
            2: return "cond_counter";
            3: return "jump_tag_miss";
            4: return "call_return_stack";
            5: return "mispredict_correction";
            6: return "flush_after_mispredict";
            default: return "unknown";
        endcase
    endfunction

    // two-bit counter after a resolved branch
    function automatic count_t count_after(input count_t cnt, input logic success,
                                           input logic taken);
        int level;
        level = cnt;
        if (!success) begin
            // a miss restarts on the weak side of the outcome
            level = taken ? 2 : 1;
        end else if (taken) begin
            level = (level < 3) ? level + 1 : 3;
        end else begin
            level = (level > 0) ? level - 1 : 0;
        end
        return level[1:0];
    endfunction

    // bht line that a resolved branch leaves behind
    function automatic bht_entry_t written_entry(input virt_t pc, input virt_t tgt,
                                                 input logic [2:0] kind, input count_t cnt,
                                                 input logic success, input logic taken);
        bht_entry_t ent;
        ent.tag     = pc[31:12];
        ent.target  = tgt;
        ent.br_type = br_type_t'(kind);
        ent.count   = count_after(cnt, success, taken);
        return ent;
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("Error %s line %0d %s: expected %h, actual %h",
                     name, line_no, field, expected, actual);
        end
    endtask

    task automatic report_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name(num));
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name(num), test_errors);
        end
        test_errors = 0;
    endtask

    // all strobes low
    task automatic drive_idle();
        fetch  <= '0;
        verify <= '0;
        flush  <= '0;
    endtask

    // hard stop if the run stalls
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not end within %0d cycles", max_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int fd;
        int n;
        int num;
        int cur_test;
        int gap;
        int quiet_wait;
        int idx;
        string op;
        logic [8*160-1:0] text;
        logic [31:0] pc, br_code, cnt, ok, tkn, ctgt;
        logic [31:0] e_valid, e_taken, e_target, e_corr, e_ctgt;
        bht_entry_t e_entry;

        seed         = 32'he380_329a;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        line_no      = 0;
        cur_test     = 0;
        rst          = 1'b1;
        fetch        = '0;
        verify       = '0;
        flush        = '0;

        // reset held over eight rising edges
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        // outputs must go quiet once out of reset
        quiet_wait = 0;
        @(negedge clk);
        while ((predict.predict_valid || predict.correction_valid) && quiet_wait < quiet_limit) begin
            @(negedge clk);
            quiet_wait++;
        end

        if (quiet_wait >= quiet_limit) begin
            $display("outputs stayed active for %0d cycles after reset", quiet_limit);
            errors++;
        end else begin
            fd = $fopen("testbench/bpu_input.txt", "r");
            if (fd == 0) begin
                $display("cannot open the stimulus file testbench/bpu_input.txt");
                errors++;
            end else begin
                while (!$feof(fd)) begin
                    text = '0;
                    n = $fgets(text, fd);
                    line_no++;
                    n = $sscanf(text, "%d %s %h %h %h %h %h %h %h %h %h %h %h",
                                num, op, pc, br_code, cnt, ok, tkn, ctgt,
                                e_valid, e_taken, e_target, e_corr, e_ctgt);
                    if (n == 13) begin
                        if (num != cur_test) begin
                            if (cur_test != 0) begin
                                report_test(cur_test);
                            end
                            cur_test = num;
                            // random quiet gap between tests
                            gap = {$random(seed)} % 4;
                            for (int i = 0; i < gap; i++) begin
                                @(posedge clk);
                                drive_idle();
                            end
                        end
                        if (op != "fetch" && op != "verify" && op != "flush" && op != "idle") begin
                            $display("unknown operation %s on line %0d", op, line_no);
                            errors++;
                        end
                        // pc column feeds both fetch and verify
                        @(posedge clk);
                        fetch.valid                   <= (op == "fetch");
                        fetch.pc                      <= pc;
                        verify.ready                  <= (op == "verify");
                        verify.pc                     <= pc;
                        verify.predict_entry.tag      <= pc[31:12];
                        verify.predict_entry.target   <= ctgt;
                        verify.predict_entry.br_type  <= br_type_t'(br_code[2:0]);
                        verify.predict_entry.count    <= cnt[1:0];
                        verify.predict_success        <= ok[0];
                        verify.is_taken               <= tkn[0];
                        verify.correct_target         <= ctgt;
                        flush.exception               <= (op == "flush");
                        // sample away from the driving edge
                        @(negedge clk);
                        check_value(test_name(num), "predict_valid", e_valid,
                                    32'(predict.predict_valid));
                        check_value(test_name(num), "is_taken", e_taken, 32'(predict.is_taken));
                        check_value(test_name(num), "target", e_target, predict.target);
                        check_value(test_name(num), "correction_valid", e_corr,
                                    32'(predict.correction_valid));
                        if (e_corr[0]) begin
                            check_value(test_name(num), "correction_target", e_ctgt,
                                        predict.correction_target);
                        end
                        idx = int'(pc[bht_bits+1:2]);
                        if (op == "fetch") begin
                            // entry read out at the fetch index
                            if (bht_model.exists(idx)) begin
                                e_entry = bht_model[idx];
                            end else begin
                                e_entry = '0;
                            end
                            check_value(test_name(num), "entry.tag", 32'(e_entry.tag),
                                        32'(predict.entry.tag));
                            check_value(test_name(num), "entry.target", e_entry.target,
                                        predict.entry.target);
                            check_value(test_name(num), "entry.br_type", 32'(e_entry.br_type),
                                        32'(predict.entry.br_type));
                            check_value(test_name(num), "entry.count", 32'(e_entry.count),
                                        32'(predict.entry.count));
                        end else if (op == "verify") begin
                            // written at the next edge, seen by later fetches
                            bht_model[idx] = written_entry(pc, ctgt, br_code[2:0], cnt[1:0],
                                                           ok[0], tkn[0]);
                        end
                    end else if (n > 0) begin
                        $display("line %0d of the stimulus file is malformed", line_no);
                        errors++;
                    end
                end
                $fclose(fd);
                if (cur_test != 0) begin
                    report_test(cur_test);
                end else begin
                    $display("no steps found in the stimulus file");
                    errors++;
                end
            end
        end

        @(posedge clk);
        drive_idle();
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock.sv */
// testbench clock
`timescale 1ns/1ps

module tb_clock #(
    parameter int half_period = 20
) (
    output logic clk
);

    // free running, 40 ns period by default
    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

/* src/bpu_top.sv */
// branch prediction unit
`timescale 1ns/1ps

module bpu_top
    import bpu_types_pkg::*;
    import bpu_bus_pkg::*;
#(
    parameter int bht_index_bits = bpu_types_pkg::bht_index_bits,
    parameter int ras_depth_bits = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  fetch_req_t fetch,
    input  verify_t    verify,
    input  flush_t     flush,
    output predict_t   predict
);

    logic       predict_enable;
    logic       ras_push;
    logic       ras_pop;
    logic       bht_we;
    bht_entry_t bht_wentry;
    bht_entry_t bht_rentry;
    virt_t      ras_top;
    virt_t      ras_push_data;

    // return lands after the call's fetch group
    assign ras_push_data = verify.pc + 32'd8;

    bpu_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .flush             (flush),
        .verify            (verify),
        .predict_enable    (predict_enable),
        .ras_push          (ras_push),
        .ras_pop           (ras_pop),
        .correction_valid  (predict.correction_valid),
        .correction_target (predict.correction_target)
    );

    bht_update u_update (
        .verify (verify),
        .we     (bht_we),
        .wentry (bht_wentry)
    );

    // same pc bits index both ports
    entry_ram #(
        .dtype     (bht_entry_t),
        .addr_bits (bht_index_bits)
    ) u_bht (
        .clk   (clk),
        .rst   (rst),
        .we    (bht_we),
        .waddr (verify.pc[bht_index_bits+1:2]),
        .wdata (bht_wentry),
        .raddr (fetch.pc[bht_index_bits+1:2]),
        .rdata (bht_rentry)
    );

    ras #(
        .depth_bits (ras_depth_bits)
    ) u_ras (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_data (ras_push_data),
        .top       (ras_top)
    );

    predict_select u_select (
        .fetch         (fetch),
        .entry         (bht_rentry),
        .ras_top       (ras_top),
        .enable        (predict_enable),
        .predict_valid (predict.predict_valid),
        .is_taken      (predict.is_taken),
        .target        (predict.target)
    );

    // entry goes back to execute for the later verify
    assign predict.entry = bht_rentry;

endmodule

/* src/bpu_ctrl.sv */
// prediction controller
// correction fsm and stack strobes
`timescale 1ns/1ps

module bpu_ctrl
    import bpu_types_pkg::*;
    import bpu_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  flush_t  flush,
    input  verify_t verify,
    output logic    predict_enable,
    output logic    ras_push,
    output logic    ras_pop,
    output logic    correction_valid,
    output virt_t   correction_target
);

    typedef enum logic {
        st_idle       = 1'b0,
        st_correction = 1'b1
    } state_t;

    state_t state;
    logic   mispredict;

    assign mispredict = verify.ready && !verify.predict_success;

    // correction lasts one cycle, flush drops it
    always_ff @(posedge clk) begin
        if (rst || flush.exception) begin
            state <= st_idle;
        end else if (state == st_correction) begin
            state <= st_idle;
        end else if (mispredict) begin
            state <= st_correction;
        end
    end

    // capture the redirect address on entry to correction
    always_ff @(posedge clk) begin
        if (state == st_idle && mispredict) begin
            correction_target <= verify.correct_target;
        end
    end

    assign predict_enable   = (state == st_idle);
    assign correction_valid = (state == st_correction);

    // one branch has one kind, so never both
    assign ras_push = verify.ready && (verify.predict_entry.br_type == br_call);
    assign ras_pop  = verify.ready && (verify.predict_entry.br_type == br_return);

endmodule

/* src/predict_select.sv */
// prediction select
// tag compare and target choice by branch kind
`timescale 1ns/1ps

module predict_select
    import bpu_types_pkg::*;
    import bpu_bus_pkg::*;
(
    input  fetch_req_t fetch,
    input  bht_entry_t entry,
    input  virt_t      ras_top,
    input  logic       enable,
    output logic       predict_valid,
    output logic       is_taken,
    output virt_t      target
);

    virt_t pc_add8;
    logic  hit;

    // fall-through past a two-instruction group
    assign pc_add8 = fetch.pc + 32'd8;

    // direct mapped, so only the tag decides
    assign hit = (fetch.pc[31:12] == entry.tag);

    // a known branch on a live fetch while not correcting
    assign predict_valid = enable && fetch.valid && hit && (entry.br_type != br_none);

    always_comb begin
        // default is sequential fetch
        is_taken = 1'b0;
        target   = pc_add8;
        if (predict_valid) begin
            case (entry.br_type)
                br_jump, br_call: begin
                    // unconditional, stored target
                    is_taken = 1'b1;
                    target   = entry.target;
                end
                br_return: begin
                    // target from the stack
                    is_taken = 1'b1;
                    target   = ras_top;
                end
                br_cond: begin
                    // counter high bit gives direction
                    if (entry.count[1]) begin
                        is_taken = 1'b1;
                        target   = entry.target;
                    end
                end
                default: begin
                    is_taken = 1'b0;
                    target   = pc_add8;
                end
            endcase
        end
    end

endmodule

/* src/ras.sv */
// return address stack
`timescale 1ns/1ps

module ras
    import bpu_types_pkg::*;
#(
    parameter int depth_bits = 3
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  logic  pop,
    input  virt_t push_data,
    output virt_t top
);

    // points at the next free slot
    logic [depth_bits-1:0] ptr;
    logic [depth_bits-1:0] top_addr;

    // pointer wraps in both directions
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (push) begin
            ptr <= ptr + 1'b1;
        end else if (pop) begin
            ptr <= ptr - 1'b1;
        end
    end

    // newest entry sits just below the pointer
    assign top_addr = ptr - 1'b1;

    // storage is zeroed on reset, so an empty stack reads zero
    entry_ram #(
        .dtype     (virt_t),
        .addr_bits (depth_bits)
    ) u_stack (
        .clk   (clk),
        .rst   (rst),
        .we    (push),
        .waddr (ptr),
        .wdata (push_data),
        .raddr (top_addr),
        .rdata (top)
    );

endmodule

/* src/bht_update.sv */
// bht write entry builder
`timescale 1ns/1ps

module bht_update
    import bpu_types_pkg::*;
    import bpu_bus_pkg::*;
(
    input  verify_t    verify,
    output logic       we,
    output bht_entry_t wentry
);

    count_t old_count;
    count_t new_count;

    assign old_count = verify.predict_entry.count;

    // every resolved branch rewrites its line
    assign we = verify.ready;

    // saturating update after a hit, weak reset after a miss
    always_comb begin
        if (verify.predict_success) begin
            if (verify.is_taken) begin
                // count up, stop at strong taken
                new_count = (old_count == cnt_st) ? cnt_st : old_count + 2'd1;
            end else begin
                // count down, stop at strong not taken
                new_count = (old_count == cnt_snt) ? cnt_snt : old_count - 2'd1;
            end
        end else begin
            // mispredict lands on the weak side of the outcome
            new_count = verify.is_taken ? cnt_wt : cnt_wnt;
        end
    end

    // tag and kind kept, target from execute
    always_comb begin
        wentry.tag     = verify.predict_entry.tag;
        wentry.target  = verify.correct_target;
        wentry.br_type = verify.predict_entry.br_type;
        wentry.count   = new_count;
    end

endmodule

/* src/entry_ram.sv */
// entry memory
// one write port, one async read port
`timescale 1ns/1ps

module entry_ram #(
    parameter type dtype = logic [31:0],
    parameter int addr_bits = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 we,
    input  logic [addr_bits-1:0] waddr,
    input  dtype                 wdata,
    input  logic [addr_bits-1:0] raddr,
    output dtype                 rdata
);

    localparam int depth = 1 << addr_bits;

    dtype mem [depth];

    // write at the edge, whole array zeroed on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read without delay
    assign rdata = mem[raddr];

endmodule

/* src/bpu_bus_pkg.sv */
// branch prediction buses
// fetch, verify, flush and prediction bundles
package bpu_bus_pkg;

    import bpu_types_pkg::*;

    // fetch group request
    typedef struct packed {
        logic  valid;
        virt_t pc;
    } fetch_req_t;

    // branch resolution from execute
    typedef struct packed {
        logic       ready;            // valid strobe
        virt_t      pc;
        bht_entry_t predict_entry;    // entry seen at predict time
        logic       predict_success;
        logic       is_taken;
        virt_t      correct_target;
    } verify_t;

    // pipeline flush sources
    typedef struct packed {
        logic exception;
    } flush_t;

    // prediction and correction toward prefetch
    typedef struct packed {
        logic       predict_valid;
        logic       is_taken;
        virt_t      target;
        bht_entry_t entry;
        logic       correction_valid;
        virt_t      correction_target;
    } predict_t;

endpackage

/* src/bpu_types_pkg.sv */
// branch prediction types
// addresses, branch kinds, counters, bht entries
package bpu_types_pkg;

    // virtual address
    typedef logic [31:0] virt_t;

    // branch kind recorded in each bht entry
    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_cond   = 3'd1,
        br_jump   = 3'd2,
        br_call   = 3'd3,
        br_return = 3'd4
    } br_type_t;

    // two-bit saturating counter
    typedef logic [1:0] count_t;

    // counter encodings, high bit set means taken
    localparam count_t cnt_snt = 2'b00;
    localparam count_t cnt_wnt = 2'b01;
    localparam count_t cnt_wt  = 2'b10;
    localparam count_t cnt_st  = 2'b11;

    // default bht index width, pc[11:2]
    localparam int bht_index_bits = 10;

    // one bht line
    typedef struct packed {
        logic [19:0] tag;      // pc[31:12]
        virt_t       target;
        br_type_t    br_type;
        count_t      count;
    } bht_entry_t;

endpackage
